/* src/ls_pkg.sv */
// load/store machine shared definitions
// bus structs, instruction word views, opcode and func3 names, sequencer states

package ls_pkg;

    parameter int xlen = 32;

    // master to memory
    typedef struct packed {
        logic            req;
        logic            we;
        logic [xlen-1:0] addr;   // word aligned on the bus
        logic [xlen-1:0] wdata;
        logic [3:0]      strb;
    } bus_req_t;

    // memory to master
    typedef struct packed {
        logic            ack;
        logic [xlen-1:0] rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    // one instruction word, two immediate layouts
    typedef union packed {
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } instr_u;

    parameter logic [6:0] op_load  = 7'b0000011;
    parameter logic [6:0] op_store = 7'b0100011;

    parameter logic [2:0] f3_b  = 3'd0;
    parameter logic [2:0] f3_h  = 3'd1;
    parameter logic [2:0] f3_w  = 3'd2;
    parameter logic [2:0] f3_bu = 3'd4;
    parameter logic [2:0] f3_hu = 3'd5;

    typedef enum logic [2:0] {
        inc, pc_wait, fetch, fetch_wait, ls_issue, ls_wait, wb
    } seq_state_t;

endpackage

/* src/ls_handler.sv */
// memory access sequencer
// fetches instructions, issues loads and stores over the bridge,
// shapes store data and extends load data for write-back

`timescale 1ns/10ps

module ls_handler (
    input  logic           clk,
    input  logic           nrst,
    input  logic [31:0]    pc,
    input  logic           busy,
    input  logic           is_load,
    input  logic           is_store,
    input  logic [2:0]     func3,
    input  logic [31:0]    eff_addr,
    input  logic [31:0]    store_val,
    input  logic           idle,
    input  logic           xfer_done,
    input  logic [31:0]    rdata,
    output logic           pc_step,
    output logic           rd_req,
    output logic           wr_req,
    output logic [31:0]    addr,
    output logic [31:0]    wdata,
    output ls_pkg::instr_u instruction,
    output logic           wb_en,
    output logic [31:0]    wb_data
);
    import ls_pkg::*;

    seq_state_t  state, next_state;
    logic        next_rd_req, next_wr_req;
    logic [31:0] next_addr, next_wdata, next_wb_data;
    instr_u      next_instruction;
    logic [31:0] st_shaped, ld_ext;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    assign pc_step = (state == inc);  // one cycle, pc unit registers it
    assign wb_en   = (state == wb);

    // store lanes: replicate so any byte offset sees the data
    always_comb begin
        case (func3)
            f3_b:    st_shaped = {4{store_val[7:0]}};
            f3_h:    st_shaped = {2{store_val[15:0]}};
            default: st_shaped = store_val;
        endcase
    end

    // load lane select and extension
    always_comb begin
        ld_byte = rdata[{eff_addr[1:0], 3'b000} +: 8];
        ld_half = eff_addr[1] ? rdata[31:16] : rdata[15:0];
        case (func3)
            f3_b:    ld_ext = {{24{ld_byte[7]}}, ld_byte};
            f3_h:    ld_ext = {{16{ld_half[15]}}, ld_half};
            f3_bu:   ld_ext = {24'b0, ld_byte};
            f3_hu:   ld_ext = {16'b0, ld_half};
            default: ld_ext = rdata;  // lw
        endcase
    end

    always_comb begin
        next_state       = state;
        next_rd_req      = rd_req;
        next_wr_req      = wr_req;
        next_addr        = addr;
        next_wdata       = wdata;
        next_wb_data     = wb_data;
        next_instruction = instruction;

        case (state)
            inc: begin
                next_state = pc_wait;
            end
            pc_wait: begin  // busy is already up here
                if (!busy) begin
                    next_state = fetch;
                end
            end
            fetch: begin
                if (idle) begin
                    next_rd_req = 1'b1;
                    next_addr   = pc;
                    next_state  = fetch_wait;
                end
            end
            fetch_wait: begin
                if (xfer_done) begin
                    next_instruction = rdata;
                    next_rd_req      = 1'b0;
                    next_state       = ls_issue;
                end
            end
            ls_issue: begin
                if (!is_load && !is_store) begin
                    next_state = inc;  // anything else is a no-op
                end else if (idle) begin
                    next_addr   = eff_addr;
                    next_rd_req = is_load;
                    next_wr_req = is_store;
                    next_wdata  = st_shaped;
                    next_state  = ls_wait;
                end
            end
            ls_wait: begin
                if (xfer_done) begin
                    next_rd_req = 1'b0;
                    next_wr_req = 1'b0;
                    if (rd_req) begin
                        next_wb_data = ld_ext;
                        next_state   = wb;
                    end else begin
                        next_state = inc;
                    end
                end
            end
            wb: begin  // regfile writes at end of this cycle
                next_state = inc;
            end
            default: next_state = fetch;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state       <= fetch;
            rd_req      <= 1'b0;
            wr_req      <= 1'b0;
            instruction <= '0;
        end else begin
            state       <= next_state;
            rd_req      <= next_rd_req;
            wr_req      <= next_wr_req;
            instruction <= next_instruction;
        end
    end

    always_ff @(posedge clk) begin
        addr    <= next_addr;
        wdata   <= next_wdata;
        wb_data <= next_wb_data;
    end

    a_req_excl: assert property (@(posedge clk) disable iff (!nrst) !(rd_req && wr_req));
    a_wb_pulse: assert property (@(posedge clk) disable iff (!nrst) wb_en |=> !wb_en);

endmodule

/* src/ls_pc.sv */
// program counter
// adds four on a step request, wraps at the memory size, busy while updating

`timescale 1ns/10ps

module ls_pc #(
    parameter int unsigned mem_words = 1024,
    parameter logic [31:0] reset_pc  = 32'h0
) (
    input  logic        clk,
    input  logic        nrst,
    input  logic        pc_step,
    output logic [31:0] pc,
    output logic        busy
);

    localparam logic [31:0] pc_mask = 32'(mem_words * 4 - 1);

    logic step_q;

    assign busy = step_q;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            step_q <= 1'b0;
            pc     <= reset_pc;
        end else begin
            step_q <= pc_step;
            if (step_q) begin
                pc <= (pc + 32'd4) & pc_mask;  // new value shows as busy drops
            end
        end
    end

endmodule

/* src/ls_decode.sv */
// instruction decoder
// load/store flags, register indices and effective address of the fetched word

`timescale 1ns/10ps

module ls_decode (
    input  ls_pkg::instr_u instruction,
    input  logic [31:0]    rs1_val,
    output logic           is_load,
    output logic           is_store,
    output logic [2:0]     func3,
    output logic [4:0]     rs1,
    output logic [4:0]     rs2,
    output logic [4:0]     rd,
    output logic [31:0]    eff_addr
);
    import ls_pkg::*;

    logic [6:0]  opcode;
    logic        ld_f3_ok, st_f3_ok;
    logic [11:0] imm;

    assign opcode = instruction.i_fmt.opcode;
    assign func3  = instruction.i_fmt.funct3;
    assign rs1    = instruction.i_fmt.rs1;
    assign rs2    = instruction.s_fmt.rs2;
    assign rd     = instruction.i_fmt.rd;

    // reserved widths fall through as no-op
    always_comb begin
        ld_f3_ok = (func3 == f3_b) || (func3 == f3_h) || (func3 == f3_w) ||
                   (func3 == f3_bu) || (func3 == f3_hu);
        st_f3_ok = (func3 == f3_b) || (func3 == f3_h) || (func3 == f3_w);
    end

    assign is_load  = (opcode == op_load) && ld_f3_ok;
    assign is_store = (opcode == op_store) && st_f3_ok;

    // immediate comes from whichever view matches the format
    always_comb begin
        if (opcode == op_store) begin
            imm = {instruction.s_fmt.imm11_5, instruction.s_fmt.imm4_0};
        end else begin
            imm = instruction.i_fmt.imm11_0;
        end
    end

    assign eff_addr = rs1_val + {{20{imm[11]}}, imm};

endmodule

/* src/ls_regfile.sv */
// register file, 32 x 32
// two combinational read ports, one write port, x0 reads as zero

`timescale 1ns/10ps

module ls_regfile (
    input  logic        clk,
    input  logic        nrst,
    input  logic [4:0]  ra,
    input  logic [4:0]  rb,
    input  logic [4:0]  wa,
    input  logic        we,
    input  logic [31:0] wd,
    output logic [31:0] qa,
    output logic [31:0] qb
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != 5'd0)) begin  // x0 stays zero
            regs[wa] <= wd;
        end
    end

    assign qa = regs[ra];  // address port
    assign qb = regs[rb];  // store data port

    a_x0_zero: assert property (@(posedge clk) disable iff (!nrst) (ra == 5'd0) |-> (qa == '0));

endmodule

/* src/ls_bus_bridge.sv */
// four-phase bus bridge
// turns level read/write requests into req/ack transfers, forms byte strobes

`timescale 1ns/10ps

module ls_bus_bridge (
    input  logic             clk,
    input  logic             nrst,
    input  logic             rd_req,
    input  logic             wr_req,
    input  logic [31:0]      addr,
    input  logic [31:0]      wdata,
    input  logic [2:0]       func3,
    output logic             idle,
    output logic             xfer_done,
    output logic [31:0]      rdata,
    output ls_pkg::bus_req_t mem_req,
    input  ls_pkg::bus_rsp_t mem_rsp
);
    import ls_pkg::*;

    typedef enum logic [1:0] {br_idle, br_req_high, br_wait_ack_low, br_done} br_state_t;

    br_state_t  state;
    logic [3:0] strb;

    always_comb begin
        case (func3)
            f3_b:    strb = 4'b0001 << addr[1:0];
            f3_h:    strb = addr[1] ? 4'b1100 : 4'b0011;
            default: strb = 4'b1111;
        endcase
        if (!wr_req) begin
            strb = 4'b1111;  // reads take the whole word
        end
    end

    assign idle      = (state == br_idle);
    assign xfer_done = (state == br_done);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state   <= br_idle;
            mem_req <= '0;
        end else begin
            case (state)
                br_idle: begin
                    if ((rd_req || wr_req) && !mem_rsp.ack) begin
                        mem_req <= '{req: 1'b1, we: wr_req, addr: {addr[31:2], 2'b00},
                                     wdata: wdata, strb: strb};
                        state   <= br_req_high;
                    end
                end
                br_req_high: begin  // fields held until ack
                    if (mem_rsp.ack) begin
                        mem_req.req <= 1'b0;
                        state       <= br_wait_ack_low;
                    end
                end
                br_wait_ack_low: begin
                    if (!mem_rsp.ack) begin
                        state <= br_done;
                    end
                end
                default: state <= br_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == br_req_high && mem_rsp.ack && !mem_req.we) begin
            rdata <= mem_rsp.rdata;
        end
    end

    // ack seen on the edge that launched req must already be low
    a_req_rise: assert property (@(posedge clk) disable iff (!nrst)
        $rose(mem_req.req) |-> !$past(mem_rsp.ack));

endmodule

/* src/ls_top.sv */
// load/store machine top level
// sequencer, pc unit, decoder, register file and bus bridge

`timescale 1ns/10ps

module ls_top #(
    parameter int unsigned mem_words = 1024,
    parameter logic [31:0] reset_pc  = 32'h0
) (
    input  logic             clk,
    input  logic             nrst,
    output ls_pkg::bus_req_t mem_req,
    input  ls_pkg::bus_rsp_t mem_rsp
);
    import ls_pkg::*;

    logic [31:0] pc, eff_addr, qa, qb, addr, wdata, rdata, wb_data;
    logic        busy, pc_step, is_load, is_store, idle, xfer_done;
    logic        rd_req, wr_req, wb_en;
    logic [2:0]  func3;
    logic [4:0]  rs1, rs2, rd;
    instr_u      instruction;

    ls_handler u_handler (
        .clk(clk), .nrst(nrst), .pc(pc), .busy(busy),
        .is_load(is_load), .is_store(is_store), .func3(func3),
        .eff_addr(eff_addr), .store_val(qb),
        .idle(idle), .xfer_done(xfer_done), .rdata(rdata),
        .pc_step(pc_step), .rd_req(rd_req), .wr_req(wr_req),
        .addr(addr), .wdata(wdata), .instruction(instruction),
        .wb_en(wb_en), .wb_data(wb_data)
    );

    ls_pc #(.mem_words(mem_words), .reset_pc(reset_pc)) u_pc (
        .clk(clk), .nrst(nrst), .pc_step(pc_step), .pc(pc), .busy(busy)
    );

    ls_decode u_decode (
        .instruction(instruction), .rs1_val(qa),
        .is_load(is_load), .is_store(is_store), .func3(func3),
        .rs1(rs1), .rs2(rs2), .rd(rd), .eff_addr(eff_addr)
    );

    ls_regfile u_regfile (
        .clk(clk), .nrst(nrst), .ra(rs1), .rb(rs2), .wa(rd),
        .we(wb_en), .wd(wb_data), .qa(qa), .qb(qb)
    );

    ls_bus_bridge u_bridge (
        .clk(clk), .nrst(nrst), .rd_req(rd_req), .wr_req(wr_req),
        .addr(addr), .wdata(wdata), .func3(func3),
        .idle(idle), .xfer_done(xfer_done), .rdata(rdata),
        .mem_req(mem_req), .mem_rsp(mem_rsp)
    );

endmodule

/* bench/ls_clkgen.sv */
// testbench clock and reset generator
// free-running clock, active-low reset released after a fixed cycle count

`timescale 1ns/10ps

module ls_clkgen #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic nrst
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        nrst = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1 nrst = 1'b1;  // released just after the edge
    end

endmodule

/* bench/ls_mem_model.sv */
// four-phase responder memory for the testbench
// random ack delay, byte strobes on writes, flags a store to the halt address

`timescale 1ns/10ps

module ls_mem_model #(
    parameter int unsigned words     = 1024,
    parameter logic [31:0] halt_addr = 32'hffc,
    parameter logic [31:0] seed      = 32'h1
) (
    input  logic             clk,
    input  logic             nrst,
    input  ls_pkg::bus_req_t mem_req,
    output ls_pkg::bus_rsp_t mem_rsp,
    output logic             halted,
    output logic             stuck
);

    localparam int aw = $clog2(words);

    logic [31:0]   mem [words];
    logic [31:0]   word, lane_mask;
    logic [aw-1:0] idx;
    int unsigned   delay, wait_cycles;

    task automatic load_word(input int unsigned i, input logic [31:0] val);
        mem[i] = val;
    endtask

    function automatic logic [31:0] peek_word(input int unsigned i);
        return mem[i];
    endfunction

    initial begin
        mem_rsp = '0;
        halted  = 1'b0;
        stuck   = 1'b0;
        void'($urandom(seed));
        forever begin
            @(posedge clk);
            if (nrst && mem_req.req && !mem_rsp.ack) begin
                delay = $urandom_range(3, 0);  // 0 to 3 cycles before ack
                repeat (delay) @(posedge clk);
                idx  = mem_req.addr[aw+1:2];
                word = mem[idx];
                if (mem_req.we) begin
                    lane_mask = {{8{mem_req.strb[3]}}, {8{mem_req.strb[2]}},
                                 {8{mem_req.strb[1]}}, {8{mem_req.strb[0]}}};
                    word     = (word & ~lane_mask) | (mem_req.wdata & lane_mask);
                    mem[idx] = word;
                end
                #1;
                mem_rsp.rdata = mem_req.we ? 32'h0 : word;
                mem_rsp.ack   = 1'b1;
                if (mem_req.we && idx == halt_addr[aw+1:2]) begin
                    halted = 1'b1;
                end
                wait_cycles = 0;
                while (mem_req.req && wait_cycles < 100) begin  // phase 3, master drops req
                    @(posedge clk);
                    wait_cycles++;
                end
                if (mem_req.req) begin
                    $display("memory model: req still high 100 cycles after ack");
                    stuck = 1'b1;
                end
                #1 mem_rsp.ack = 1'b0;
            end
        end
    end

endmodule

/* bench/ls_tb.sv */
// testbench for the load/store machine
// builds a load/store program from a test table, runs it against the bus memory
// model, then checks the result words and the bus transfer sequence

`timescale 1ns/10ps

module ls_tb;
    import ls_pkg::*;

    localparam int unsigned mem_words   = 1024;
    localparam logic [31:0] reset_pc    = 32'h0;
    localparam logic [11:0] result_base = 12'h400;
    localparam logic [11:0] halt_imm    = 12'hffc;
    localparam int          run_timeout = 5000;

    typedef struct {
        string       name;
        logic [2:0]  ld_f3;
        logic [11:0] daddr;  // load address, low bits pick the lane
        logic [31:0] dword;
        logic [2:0]  st_f3;
        logic [4:0]  rd;
    } row_t;

    logic        clk, nrst, halted, stuck;
    bus_req_t    mem_req, prev_req;
    bus_rsp_t    mem_rsp;
    logic        prev_ack, expect_fetch, exp_we;
    logic [31:0] exp_pc, exp_daddr;
    row_t        rows [16];
    logic [1:0]  prog_kind [64];  // 0 no-op, 1 load, 2 store
    logic [31:0] prog_daddr [64];
    int          n_rows, prog_len, halt_pos, errors, checks, fetch_count, cycles;

    ls_clkgen #(.period_ns(100), .reset_cycles(10)) clkgen0 (.clk(clk), .nrst(nrst));

    ls_top #(.mem_words(mem_words), .reset_pc(reset_pc)) dut0 (
        .clk(clk), .nrst(nrst), .mem_req(mem_req), .mem_rsp(mem_rsp)
    );

    ls_mem_model #(.words(mem_words), .halt_addr(32'hffc), .seed(32'ha5dd20ff)) mem0 (
        .clk(clk), .nrst(nrst), .mem_req(mem_req), .mem_rsp(mem_rsp),
        .halted(halted), .stuck(stuck)
    );

    function automatic logic [31:0] fill_word(input int unsigned idx);
        return {~idx[15:0], idx[15:0]} ^ 32'h3c5a_a5c3;
    endfunction

    function automatic logic [31:0] load_instr(input logic [4:0] rd, input logic [2:0] f3,
                                               input logic [11:0] imm);
        return {imm, 5'd0, f3, rd, op_load};
    endfunction

    function automatic logic [31:0] store_instr(input logic [4:0] rs2, input logic [2:0] f3,
                                                input logic [11:0] imm);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], op_store};
    endfunction

    // value a load leaves in its register
    function automatic logic [31:0] lane_value(input logic [2:0] f3, input logic [1:0] off,
                                               input logic [31:0] w);
        logic [31:0] sh, v;
        sh = w >> (8 * off);
        case (f3)
            f3_b:    v = {{24{sh[7]}}, sh[7:0]};
            f3_h:    v = {{16{sh[15]}}, sh[15:0]};
            f3_bu:   v = {24'h0, sh[7:0]};
            f3_hu:   v = {16'h0, sh[15:0]};
            default: v = w;
        endcase
        return v;
    endfunction

    // word after a store of val at byte offset off
    function automatic logic [31:0] merged_word(input logic [2:0] f3, input logic [1:0] off,
                                                input logic [31:0] old, input logic [31:0] val);
        logic [31:0] mask;
        case (f3)
            f3_b:    mask = 32'h0000_00ff << (8 * off);
            f3_h:    mask = 32'h0000_ffff << (8 * off);
            default: mask = 32'hffff_ffff;
        endcase
        return (old & ~mask) | ((val << (8 * off)) & mask);
    endfunction

    function automatic logic [1:0] store_lane(input int i);
        return (rows[i].st_f3 == f3_w) ? 2'd0 : rows[i].daddr[1:0];
    endfunction

    task automatic add_row(input string name, input logic [2:0] ld_f3, input logic [11:0] daddr,
                           input logic [31:0] dword, input logic [2:0] st_f3, input logic [4:0] rd);
        rows[n_rows].name  = name;
        rows[n_rows].ld_f3 = ld_f3;
        rows[n_rows].daddr = daddr;
        rows[n_rows].dword = dword;
        rows[n_rows].st_f3 = st_f3;
        rows[n_rows].rd    = rd;
        n_rows++;
    endtask

    task automatic emit(input logic [31:0] w, input logic [1:0] kind, input logic [11:0] imm);
        mem0.load_word((reset_pc >> 2) + prog_len, w);
        prog_kind[prog_len]  = kind;
        prog_daddr[prog_len] = {{20{imm[11]}}, imm} & 32'hffff_fffc;
        prog_len++;
    endtask

    task automatic assemble_program();
        logic [11:0] st_imm;
        for (int i = 0; i < n_rows; i++) begin
            st_imm = result_base + 12'(4 * i) + {10'h0, store_lane(i)};
            emit(load_instr(rows[i].rd, rows[i].ld_f3, rows[i].daddr), 2'd1, rows[i].daddr);
            emit(store_instr(rows[i].rd, rows[i].st_f3, st_imm), 2'd2, st_imm);
            if (i == 3 || i == 11) begin
                emit({12'd5, 5'd0, 3'd0, 5'd5, 7'b0010011}, 2'd0, 12'h0);  // addi x5, alu op
            end else if (i == 7) begin
                emit(load_instr(5'd1, 3'd3, 12'h200), 2'd0, 12'h0);  // reserved width
            end
        end
        halt_pos = prog_len;
        emit(store_instr(5'd0, f3_w, halt_imm), 2'd2, halt_imm);
        emit({12'd5, 5'd0, 3'd0, 5'd5, 7'b0010011}, 2'd0, 12'h0);
    endtask

    // bus sequence expected from the program: fetch, then one data transfer per load/store
    task automatic follow_transfer(input bus_req_t r);
        int pidx;
        if (expect_fetch) begin
            pidx = int'((exp_pc - reset_pc) >> 2);
            if (r.we || r.addr != exp_pc) begin
                $display("error fetch_%0d: expected addr %h, actual addr %h we %b",
                         fetch_count, exp_pc, r.addr, r.we);
                errors++;
            end
            if (pidx < prog_len && prog_kind[pidx] != 2'd0) begin
                expect_fetch = 1'b0;
                exp_we       = (prog_kind[pidx] == 2'd2);
                exp_daddr    = prog_daddr[pidx];
            end
            fetch_count++;
            exp_pc = exp_pc + 32'd4;
        end else begin
            if (r.we != exp_we || r.addr != exp_daddr) begin
                $display("error data_%0d: expected we %b addr %h, actual we %b addr %h",
                         fetch_count, exp_we, exp_daddr, r.we, r.addr);
                errors++;
            end
            expect_fetch = 1'b1;
        end
    endtask

    always @(negedge clk) begin
        if (nrst && !halted) begin
            if (mem_req.req && !prev_req.req) begin
                if (prev_ack) begin
                    $display("bus protocol: req rose while ack was still high");
                    errors++;
                end
                follow_transfer(mem_req);
            end
            if (prev_req.req && mem_req.req && mem_req != prev_req) begin
                $display("bus protocol: request fields changed while req was high");
                errors++;
            end
            if (prev_req.req && !mem_req.req && !prev_ack) begin
                $display("bus protocol: req dropped before ack was seen");
                errors++;
            end
        end
        prev_req = mem_req;
        prev_ack = mem_rsp.ack;
    end

    task automatic check_results();
        logic [31:0] loaded, expected, actual;
        int unsigned idx;
        for (int i = 0; i < n_rows; i++) begin
            idx      = (result_base >> 2) + i;
            loaded   = (rows[i].rd == 5'd0) ? 32'h0 :
                       lane_value(rows[i].ld_f3, rows[i].daddr[1:0], rows[i].dword);
            expected = merged_word(rows[i].st_f3, store_lane(i), fill_word(idx), loaded);
            actual   = mem0.peek_word(idx);
            checks++;
            if (actual !== expected) begin
                $display("error %s: expected %h, actual %h", rows[i].name, expected, actual);
                errors++;
            end
        end
    endtask

    initial begin
        errors       = 0;
        checks       = 0;
        fetch_count  = 0;
        n_rows       = 0;
        prog_len     = 0;
        expect_fetch = 1'b1;
        exp_we       = 1'b0;
        exp_pc       = reset_pc;
        exp_daddr    = 32'h0;
        prev_req     = '0;
        prev_ack     = 1'b0;

        add_row("lw_sw",     f3_w,  12'h200, 32'h8bad_f00d, f3_w, 5'd1);
        add_row("lb_lane0",  f3_b,  12'h204, 32'h1234_5680, f3_w, 5'd1);
        add_row("lb_lane1",  f3_b,  12'h209, 32'ha5a5_fe5a, f3_w, 5'd1);
        add_row("lb_lane2",  f3_b,  12'h20e, 32'h1181_ffff, f3_w, 5'd1);
        add_row("lb_lane3",  f3_b,  12'h213, 32'h7e00_00ff, f3_w, 5'd1);
        add_row("lh_lane0",  f3_h,  12'h214, 32'h1234_8001, f3_w, 5'd1);
        add_row("lh_lane2",  f3_h,  12'h21a, 32'h7ffe_c3c3, f3_w, 5'd1);
        add_row("lbu_lane1", f3_bu, 12'h21d, 32'h0000_f000, f3_w, 5'd1);
        add_row("lhu_lane2", f3_hu, 12'h222, 32'h9abc_1234, f3_w, 5'd1);
        add_row("sb_lane1",  f3_bu, 12'h225, 32'h5566_c777, f3_b, 5'd1);
        add_row("sb_lane3",  f3_b,  12'h22b, 32'h3d00_0000, f3_b, 5'd1);
        add_row("sh_lane2",  f3_hu, 12'h22e, 32'hbeef_0000, f3_h, 5'd1);
        add_row("sh_lane0",  f3_h,  12'h230, 32'h0000_8421, f3_h, 5'd1);
        add_row("x0_load",   f3_w,  12'h234, 32'hffff_ffff, f3_w, 5'd0);

        for (int unsigned i = 0; i < mem_words; i++) begin
            mem0.load_word(i, fill_word(i));
        end
        for (int i = 0; i < n_rows; i++) begin
            mem0.load_word(rows[i].daddr >> 2, rows[i].dword);
        end
        assemble_program();

        cycles = 0;
        while (!halted && cycles < run_timeout) begin
            @(posedge clk);
            cycles++;
        end

        if (!halted) begin
            $display("timeout: no store to the halt address within %0d cycles", run_timeout);
            errors++;
        end else begin
            check_results();
            checks++;
            if (fetch_count != halt_pos + 1) begin
                $display("error fetch_count: expected %0d, actual %0d", halt_pos + 1, fetch_count);
                errors++;
            end
        end
        if (stuck) begin
            $display("memory model saw a transfer that never completed");
            errors++;
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* compile.f */
src/ls_pkg.sv
src/ls_handler.sv
src/ls_pc.sv
src/ls_decode.sv
src/ls_regfile.sv
src/ls_bus_bridge.sv
src/ls_top.sv
bench/ls_clkgen.sv
bench/ls_mem_model.sv
bench/ls_tb.sv

/* Makefile */
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f compile.f --top-module ls_tb -Mdir obj_dir

run: build
	./obj_dir/Vls_tb | tee sim.log
	grep -q "Everything OK" sim.log

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module ls_tb

clean:
	rm -rf obj_dir sim.log
